// File: rtl/snoop_config.svh
// ----------------------------------------
// Trace snooper configuration
// Widths, record buffer depth and
// register map of the snooper
// ----------------------------------------
`ifndef SNOOP_CONFIG_SVH
`define SNOOP_CONFIG_SVH

`define SNOOP_PC_W       32
`define SNOOP_DATA_W     32
`define SNOOP_ADDR_W     3
`define SNOOP_FIFO_DEPTH 8
// Must hold 0 up to the full depth
`define SNOOP_CNT_W      4
`define SNOOP_NUM_CORES  2

// Register map
`define SNOOP_REG_CTRL      3'd0
`define SNOOP_REG_WATERMARK 3'd1
`define SNOOP_REG_TRIG_ADDR 3'd2
`define SNOOP_REG_STATUS    3'd3
`define SNOOP_REG_PC_SRC    3'd4
`define SNOOP_REG_PC_DST    3'd5
`define SNOOP_REG_OPCODE    3'd6
`define SNOOP_REG_POP       3'd7

`endif

// File: rtl/snoop_pkg.sv
// ----------------------------------------
// Trace snooper types
// Trace record, privilege level and
// register port word types
// ----------------------------------------
`default_nettype none

`include "snoop_config.svh"

package snoop_pkg;

  // RISC-V privilege level as seen by the core
  typedef logic [1:0] priv_lvl_t;

  // Control-transfer kind reported by the core
  typedef logic [3:0] ctr_type_t;

  typedef logic [`SNOOP_DATA_W-1:0] data_t;
  typedef logic [`SNOOP_ADDR_W-1:0] reg_addr_t;

  // ----------------------------------------
  // Trace record, 102 bits
  // ----------------------------------------
  typedef struct packed {
    priv_lvl_t                 priv;
    ctr_type_t                 ctr_type;
    logic [`SNOOP_PC_W-1:0]    pc_src;
    logic [`SNOOP_PC_W-1:0]    pc_dst;
    logic [`SNOOP_DATA_W-1:0]  opcode;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: rtl/trace_buf_if.sv
// ----------------------------------------
// Trace buffer access interface
// Head record and fill state out of the
// buffer, pop and clear back into it
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

interface trace_buf_if import snoop_pkg::*; ();

  trace_rec_t              head;
  logic [`SNOOP_CNT_W-1:0] count;
  logic                    empty;
  logic                    pop;
  // Clears the sticky overflow flag
  logic                    clear;

  modport buf_mp (output head, count, empty, input pop, clear);
  modport reg_mp (input head, count, empty, output pop, clear);

endinterface

`default_nettype wire

// File: rtl/snoop_trace_select.sv
// ----------------------------------------
// Trace select
// Picks one core's branch trace and
// registers it as a trace record
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

module snoop_trace_select import snoop_pkg::*; (
  input  wire logic                                             clk_i,
  input  wire logic                                             reset_i,
  input  wire logic                                             enable_i,
  input  wire logic                                             core_select_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0]                 valid_i,
  input  wire priv_lvl_t [`SNOOP_NUM_CORES-1:0]                 priv_i,
  input  wire ctr_type_t [`SNOOP_NUM_CORES-1:0]                 ctr_type_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_W-1:0]   pc_src_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_W-1:0]   pc_dst_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_DATA_W-1:0] opcode_i,
  output logic                                                  rec_valid_o,
  output trace_rec_t                                            rec_o
);

  logic       sel_valid;
  trace_rec_t sel_rec;

  // Core mux
  assign sel_valid        = enable_i & valid_i[core_select_i];
  assign sel_rec.priv     = priv_i[core_select_i];
  assign sel_rec.ctr_type = ctr_type_i[core_select_i];
  assign sel_rec.pc_src   = pc_src_i[core_select_i];
  assign sel_rec.pc_dst   = pc_dst_i[core_select_i];
  assign sel_rec.opcode   = opcode_i[core_select_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_valid_o <= 1'b0;
    end else begin
      rec_valid_o <= sel_valid;
    end
  end

  // Payload only loads on an accepted trace
  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      rec_o <= sel_rec;
    end
  end

endmodule

`default_nettype wire

// File: rtl/snoop_trace_buffer.sv
// ----------------------------------------
// Trace record buffer
// Circular FIFO of trace records with a
// fill count, sticky overflow flag and a
// watermark interrupt
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

module snoop_trace_buffer import snoop_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    rec_valid_i,
  input  wire trace_rec_t              rec_i,
  input  wire logic [`SNOOP_CNT_W-1:0] watermark_i,
  trace_buf_if.buf_mp                  buf_if,
  output logic                         overflow_o,
  output logic                         watermark_irq_o
);

  localparam int DEPTH = `SNOOP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = `SNOOP_CNT_W;

  trace_rec_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == CNT_W'(DEPTH));
  // Records arriving while full are lost
  assign push = rec_valid_i & ~full;
  assign pop  = buf_if.pop & ~buf_if.empty;

  assign buf_if.head  = mem[rd_ptr_q];
  assign buf_if.count = count_q;
  assign buf_if.empty = (count_q == '0);

  // ----------------------------------------
  // Pointers and fill state
  // ----------------------------------------
  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // A drop on the clearing edge still counts
      if (rec_valid_i && full) begin
        overflow_o <= 1'b1;
      end else if (buf_if.clear) begin
        overflow_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= rec_i;
    end
  end

  // Watermark of zero disables the interrupt
  assign watermark_irq_o = (watermark_i != '0) && (count_q >= watermark_i);

endmodule

`default_nettype wire

// File: rtl/snoop_trigger.sv
// ----------------------------------------
// Branch-target trigger
// Flags a record whose target matches
// the programmed trigger address
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snoop_trigger import snoop_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       rec_valid_i,
  input  wire trace_rec_t rec_i,
  input  wire logic       trig_en_i,
  input  wire data_t      trig_addr_i,
  input  wire logic       clear_i,
  output logic            flag_o
);

  logic hit;

  assign hit = rec_valid_i & trig_en_i & (rec_i.pc_dst == trig_addr_i);

  // Sticky until software clears it, a hit on the same edge wins
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flag_o <= 1'b0;
    end else if (hit) begin
      flag_o <= 1'b1;
    end else if (clear_i) begin
      flag_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/snoop_cfg_regs.sv
// ----------------------------------------
// Snooper register block
// Four-phase req/ack register slave with
// control, watermark and trigger address,
// status and head-record reads, and pop
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

module snoop_cfg_regs import snoop_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    cfg_req_i,
  input  wire logic                    cfg_we_i,
  input  wire reg_addr_t               cfg_addr_i,
  input  wire data_t                   cfg_wdata_i,
  output logic                         cfg_ack_o,
  output data_t                        cfg_rdata_o,
  trace_buf_if.reg_mp                  buf_if,
  input  wire logic                    overflow_i,
  input  wire logic                    trig_flag_i,
  output logic                         enable_o,
  output logic                         core_select_o,
  output logic                         trig_en_o,
  output logic [`SNOOP_CNT_W-1:0]      watermark_o,
  output data_t                        trig_addr_o
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_t;

  state_t                  state_q;
  logic [2:0]              ctrl_q;
  logic [`SNOOP_CNT_W-1:0] wmark_q;
  data_t                   trig_addr_q;
  data_t                   rd_data;
  logic                    access;
  logic                    wr_en;

  // One access per request, taken in idle only
  assign access = (state_q == ST_IDLE) & cfg_req_i;
  assign wr_en  = access & cfg_we_i;

  assign cfg_ack_o = (state_q == ST_ACK);

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      cfg_rdata_o <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cfg_req_i) begin
            state_q     <= ST_ACK;
            cfg_rdata_o <= rd_data;
          end
        end
        ST_ACK: begin
          // Hold ack until the master lets go
          if (!cfg_req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Writable registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q      <= '0;
      wmark_q     <= '0;
      trig_addr_q <= '0;
    end else if (wr_en) begin
      case (cfg_addr_i)
        `SNOOP_REG_CTRL:      ctrl_q      <= cfg_wdata_i[2:0];
        `SNOOP_REG_WATERMARK: wmark_q     <= cfg_wdata_i[`SNOOP_CNT_W-1:0];
        `SNOOP_REG_TRIG_ADDR: trig_addr_q <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Read mux, sampled into cfg_rdata_o with the ack
  always_comb begin
    rd_data = '0;
    case (cfg_addr_i)
      `SNOOP_REG_CTRL:      rd_data[2:0] = ctrl_q;
      `SNOOP_REG_WATERMARK: rd_data[`SNOOP_CNT_W-1:0] = wmark_q;
      `SNOOP_REG_TRIG_ADDR: rd_data = trig_addr_q;
      `SNOOP_REG_STATUS: begin
        rd_data[`SNOOP_CNT_W-1:0] = buf_if.count;
        rd_data[4]                = buf_if.empty;
        rd_data[5]                = overflow_i;
        rd_data[6]                = trig_flag_i;
      end
      `SNOOP_REG_PC_SRC:    rd_data[`SNOOP_PC_W-1:0] = buf_if.head.pc_src;
      `SNOOP_REG_PC_DST:    rd_data[`SNOOP_PC_W-1:0] = buf_if.head.pc_dst;
      `SNOOP_REG_OPCODE:    rd_data = buf_if.head.opcode;
      `SNOOP_REG_POP:       rd_data[5:0] = {buf_if.head.ctr_type, buf_if.head.priv};
      default:              rd_data = '0;
    endcase
  end

  // Pop on the access edge, bit 0 also clears the sticky flags
  assign buf_if.pop   = wr_en & (cfg_addr_i == `SNOOP_REG_POP);
  assign buf_if.clear = buf_if.pop & cfg_wdata_i[0];

  assign enable_o      = ctrl_q[0];
  assign core_select_o = ctrl_q[1];
  assign trig_en_o     = ctrl_q[2];
  assign watermark_o   = wmark_q;
  assign trig_addr_o   = trig_addr_q;

endmodule

`default_nettype wire

// File: rtl/snoop_top.sv
// ----------------------------------------
// Control-flow trace snooper
// Core trace select, record buffer,
// branch trigger and register port
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

module snoop_top import snoop_pkg::*; (
  input  wire logic                                             clk_i,
  input  wire logic                                             reset_i,
  // Branch-trace ports of the cores
  input  wire logic      [`SNOOP_NUM_CORES-1:0]                 valid_i,
  input  wire priv_lvl_t [`SNOOP_NUM_CORES-1:0]                 priv_i,
  input  wire ctr_type_t [`SNOOP_NUM_CORES-1:0]                 ctr_type_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_W-1:0]   pc_src_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_W-1:0]   pc_dst_i,
  input  wire logic      [`SNOOP_NUM_CORES-1:0][`SNOOP_DATA_W-1:0] opcode_i,
  // Register port
  input  wire logic                                             cfg_req_i,
  input  wire logic                                             cfg_we_i,
  input  wire reg_addr_t                                        cfg_addr_i,
  input  wire data_t                                            cfg_wdata_i,
  output logic                                                  cfg_ack_o,
  output data_t                                                 cfg_rdata_o,
  // Interrupts
  output logic                                                  trigger_irq_o,
  output logic                                                  watermark_irq_o
);

  logic                    enable;
  logic                    core_select;
  logic                    trig_en;
  logic [`SNOOP_CNT_W-1:0] watermark;
  data_t                   trig_addr;
  logic                    rec_valid;
  trace_rec_t              rec;
  logic                    overflow;
  logic                    trig_flag;

  trace_buf_if trace_buf_if_i ();

  snoop_trace_select trace_select_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .enable_i      (enable),
    .core_select_i (core_select),
    .valid_i       (valid_i),
    .priv_i        (priv_i),
    .ctr_type_i    (ctr_type_i),
    .pc_src_i      (pc_src_i),
    .pc_dst_i      (pc_dst_i),
    .opcode_i      (opcode_i),
    .rec_valid_o   (rec_valid),
    .rec_o         (rec)
  );

  snoop_trace_buffer trace_buffer_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rec_valid_i     (rec_valid),
    .rec_i           (rec),
    .watermark_i     (watermark),
    .buf_if          (trace_buf_if_i.buf_mp),
    .overflow_o      (overflow),
    .watermark_irq_o (watermark_irq_o)
  );

  // Shares the clear pulse of the buffer
  snoop_trigger trigger_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rec_valid_i (rec_valid),
    .rec_i       (rec),
    .trig_en_i   (trig_en),
    .trig_addr_i (trig_addr),
    .clear_i     (trace_buf_if_i.clear),
    .flag_o      (trig_flag)
  );

  snoop_cfg_regs cfg_regs_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_req_i     (cfg_req_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_ack_o     (cfg_ack_o),
    .cfg_rdata_o   (cfg_rdata_o),
    .buf_if        (trace_buf_if_i.reg_mp),
    .overflow_i    (overflow),
    .trig_flag_i   (trig_flag),
    .enable_o      (enable),
    .core_select_o (core_select),
    .trig_en_o     (trig_en),
    .watermark_o   (watermark),
    .trig_addr_o   (trig_addr)
  );

  assign trigger_irq_o = trig_flag;

endmodule

`default_nettype wire

// File: bench/snoop_tb.sv
// ----------------------------------------
// Trace snooper testbench
// Random two-core traces checked against
// a record queue and shadow registers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "snoop_config.svh"

module snoop_tb import snoop_pkg::*; ();

  localparam int NC      = `SNOOP_NUM_CORES;
  localparam int CNT_W   = `SNOOP_CNT_W;
  localparam int TIMEOUT = 50;

  logic                                 clk_i;
  logic                                 reset_i;
  logic      [NC-1:0]                   valid_i;
  priv_lvl_t [NC-1:0]                   priv_i;
  ctr_type_t [NC-1:0]                   ctr_type_i;
  logic      [NC-1:0][`SNOOP_PC_W-1:0]   pc_src_i;
  logic      [NC-1:0][`SNOOP_PC_W-1:0]   pc_dst_i;
  logic      [NC-1:0][`SNOOP_DATA_W-1:0] opcode_i;
  logic                                 cfg_req_i;
  logic                                 cfg_we_i;
  reg_addr_t                            cfg_addr_i;
  data_t                                cfg_wdata_i;
  logic                                 cfg_ack_o;
  data_t                                cfg_rdata_o;
  logic                                 trigger_irq_o;
  logic                                 watermark_irq_o;

  // Reference model state
  logic [31:0]      lcg_state;
  trace_rec_t       model_q[$];
  logic [2:0]       ctrl_sh;
  logic [CNT_W-1:0] wmark_sh;
  data_t            trig_sh;
  logic             ovf_m;
  logic             trig_m;

  snoop_top dut_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .valid_i         (valid_i),
    .priv_i          (priv_i),
    .ctr_type_i      (ctr_type_i),
    .pc_src_i        (pc_src_i),
    .pc_dst_i        (pc_dst_i),
    .opcode_i        (opcode_i),
    .cfg_req_i       (cfg_req_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_ack_o       (cfg_ack_o),
    .cfg_rdata_o     (cfg_rdata_o),
    .trigger_irq_o   (trigger_irq_o),
    .watermark_irq_o (watermark_irq_o)
  );

  always #2 clk_i = ~clk_i;

  // High half folded into the weak low LCG bits
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "register value mismatch");
    end
  endtask

  task automatic check_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "trace record mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      $display("Verification failed");
      $fatal(1, "signal level mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Verification failed");
    $fatal(1, "handshake did not complete");
  endtask

  task automatic check_irqs();
    check_bit("watermark_irq", (wmark_sh != '0) && (model_q.size() >= int'(wmark_sh)),
              watermark_irq_o);
    check_bit("trigger_irq", trig_m, trigger_irq_o);
  endtask

  // ----------------------------------------
  // Four-phase register access
  // ----------------------------------------
  // Entered and left one small delay after a rising edge
  task automatic reg_access(input logic we, input reg_addr_t addr, input data_t wdata,
                            output data_t rdata);
    int waited;
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    waited      = 0;
    do begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT) fail_timeout("cfg_ack_o to rise");
    end while (!cfg_ack_o);
    // Ack follows the first edge that sees the request
    check_bit("ack_rise_latency", 1'b1, waited == 1);
    rdata     = cfg_rdata_o;
    cfg_req_i = 1'b0;
    waited    = 0;
    do begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT) fail_timeout("cfg_ack_o to fall");
    end while (cfg_ack_o);
    check_bit("ack_fall_latency", 1'b1, waited == 1);
    check_irqs();
  endtask

  task automatic reg_write(input reg_addr_t addr, input data_t wdata);
    data_t unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input reg_addr_t addr, output data_t rdata);
    reg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic check_status(input string name);
    data_t rd;
    data_t exp;
    exp                 = '0;
    exp[CNT_W-1:0]      = CNT_W'(model_q.size());
    exp[4]              = (model_q.size() == 0);
    exp[5]              = ovf_m;
    exp[6]              = trig_m;
    reg_read(`SNOOP_REG_STATUS, rd);
    check_data(name, exp, rd);
  endtask

  // Reads the head fields and pops the record
  task automatic pop_record(input logic clear);
    data_t      rd;
    trace_rec_t got;
    trace_rec_t exp;
    exp = model_q[0];
    reg_read(`SNOOP_REG_PC_SRC, rd);
    got.pc_src = rd;
    reg_read(`SNOOP_REG_PC_DST, rd);
    got.pc_dst = rd;
    reg_read(`SNOOP_REG_OPCODE, rd);
    got.opcode = rd;
    reg_read(`SNOOP_REG_POP, rd);
    got.priv     = rd[1:0];
    got.ctr_type = rd[5:2];
    check_rec("head_record", exp, got);
    void'(model_q.pop_front());
    if (clear) begin
      ovf_m  = 1'b0;
      trig_m = 1'b0;
    end
    reg_write(`SNOOP_REG_POP, {31'b0, clear});
  endtask

  task automatic drain_records();
    while (model_q.size() > 0) pop_record(1'b0);
  endtask

  // ----------------------------------------
  // Trace stimulus and model update
  // ----------------------------------------
  // hit_cycle forces a valid trace to the trigger address on the selected core
  task automatic drive_traces(input int n, input logic force_valid, input int hit_cycle);
    logic [31:0] r;
    logic        sel;
    trace_rec_t  rec;
    sel = ctrl_sh[1];
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < NC; c++) begin
        r             = next_rand();
        valid_i[c]    = force_valid | r[0];
        priv_i[c]     = r[2:1];
        ctr_type_i[c] = r[6:3];
        pc_src_i[c]   = next_rand();
        pc_dst_i[c]   = next_rand();
        opcode_i[c]   = next_rand();
      end
      if (i == hit_cycle) begin
        valid_i[sel]  = 1'b1;
        pc_dst_i[sel] = trig_sh;
      end
      if (ctrl_sh[0] && valid_i[sel]) begin
        rec.priv     = priv_i[sel];
        rec.ctr_type = ctr_type_i[sel];
        rec.pc_src   = pc_src_i[sel];
        rec.pc_dst   = pc_dst_i[sel];
        rec.opcode   = opcode_i[sel];
        if (ctrl_sh[2] && (rec.pc_dst == trig_sh)) trig_m = 1'b1;
        if (model_q.size() < `SNOOP_FIFO_DEPTH) begin
          model_q.push_back(rec);
        end else begin
          ovf_m = 1'b1;
        end
      end
      @(posedge clk_i);
      #1;
    end
    valid_i = '0;
    // Two idle cycles let the last record reach the buffer
    repeat (2) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    data_t wr;
    data_t rd;
    lcg_state   = 32'd98;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    valid_i     = '0;
    priv_i      = '0;
    ctr_type_i  = '0;
    pc_src_i    = '0;
    pc_dst_i    = '0;
    opcode_i    = '0;
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    ctrl_sh     = '0;
    wmark_sh    = '0;
    trig_sh     = '0;
    ovf_m       = 1'b0;
    trig_m      = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bit("reset_ack", 1'b0, cfg_ack_o);
    check_irqs();
    check_status("reset_status");
    reg_read(`SNOOP_REG_CTRL, rd);
    check_data("reset_ctrl", '0, rd);
    reg_read(`SNOOP_REG_WATERMARK, rd);
    check_data("reset_watermark", '0, rd);
    reg_read(`SNOOP_REG_TRIG_ADDR, rd);
    check_data("reset_trig_addr", '0, rd);

    // Register readback
    for (int i = 0; i < 8; i++) begin
      wr      = next_rand();
      ctrl_sh = wr[2:0];
      reg_write(`SNOOP_REG_CTRL, wr);
      reg_read(`SNOOP_REG_CTRL, rd);
      check_data("ctrl_readback", wr & 32'h7, rd);
      wr       = next_rand();
      wmark_sh = wr[CNT_W-1:0];
      reg_write(`SNOOP_REG_WATERMARK, wr);
      reg_read(`SNOOP_REG_WATERMARK, rd);
      check_data("watermark_readback", wr & 32'hf, rd);
      wr      = next_rand();
      trig_sh = wr;
      reg_write(`SNOOP_REG_TRIG_ADDR, wr);
      reg_read(`SNOOP_REG_TRIG_ADDR, rd);
      check_data("trig_addr_readback", wr, rd);
    end

    // Core select and watermark
    for (int s = 0; s < NC; s++) begin
      wr       = next_rand();
      wmark_sh = {1'b0, wr[2:0]} + 4'd1;
      reg_write(`SNOOP_REG_WATERMARK, data_t'(wmark_sh));
      ctrl_sh = {1'b0, s[0], 1'b1};
      reg_write(`SNOOP_REG_CTRL, data_t'(ctrl_sh));
      drive_traces(6, 1'b0, -1);
      check_status("select_status");
      drain_records();
      check_status("select_drained");
    end
    ctrl_sh = 3'b000;
    reg_write(`SNOOP_REG_CTRL, data_t'(ctrl_sh));
    drive_traces(10, 1'b0, -1);
    check_status("disabled_status");

    // Overflow keeps the first eight
    ctrl_sh  = 3'b001;
    reg_write(`SNOOP_REG_CTRL, data_t'(ctrl_sh));
    wmark_sh = 4'd8;
    reg_write(`SNOOP_REG_WATERMARK, data_t'(wmark_sh));
    drive_traces(12, 1'b1, -1);
    check_status("overflow_status");
    pop_record(1'b1);
    check_status("overflow_cleared");
    drain_records();

    // Branch-target trigger
    trig_sh = next_rand();
    reg_write(`SNOOP_REG_TRIG_ADDR, trig_sh);
    ctrl_sh = 3'b101;
    reg_write(`SNOOP_REG_CTRL, data_t'(ctrl_sh));
    drive_traces(6, 1'b0, 2);
    check_bit("trigger_set", 1'b1, trigger_irq_o);
    drive_traces(4, 1'b0, -1);
    check_bit("trigger_sticky", 1'b1, trigger_irq_o);
    drain_records();
    ovf_m  = 1'b0;
    trig_m = 1'b0;
    reg_write(`SNOOP_REG_POP, 32'h1);
    check_bit("trigger_cleared", 1'b0, trigger_irq_o);
    ctrl_sh = 3'b001;
    reg_write(`SNOOP_REG_CTRL, data_t'(ctrl_sh));
    drive_traces(6, 1'b0, 2);
    check_bit("trigger_disabled", 1'b0, trigger_irq_o);
    drain_records();
    check_status("final_status");

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/snoop_pkg.sv
rtl/trace_buf_if.sv
rtl/snoop_trace_select.sv
rtl/snoop_trace_buffer.sv
rtl/snoop_trigger.sv
rtl/snoop_cfg_regs.sv
rtl/snoop_top.sv
bench/snoop_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the trace snooper testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f sim.f --top-module snoop_tb -o snoop_sim

# A failing run still leaves its log for the search below
./obj_dir/snoop_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "run.sh: simulation PASSED"
else
  echo "run.sh: simulation FAILED"
  exit 1
fi
